//--- verilog/tag_pkg.sv
`default_nettype none

package tag_pkg;

  localparam int tag_id_width_lp      = 2;  // Node id bits in a frame
  localparam int tag_payload_width_lp = 8;  // Payload bits in a frame
  localparam int tag_num_nodes_lp     = 4;  // One register per node id

  // Start bit, id, payload and even parity bit
  localparam int tag_frame_bits_lp = 1 + tag_id_width_lp + tag_payload_width_lp + 1;

  localparam int tag_cnt_width_lp = $clog2(tag_frame_bits_lp);  // Bit counter width

  // Node register contents, node 0 in the low byte
  typedef logic [tag_num_nodes_lp-1:0][tag_payload_width_lp-1:0] tag_node_array_t;

  typedef enum logic {
    SER_IDLE,  // Raw port forwarded, packet port open
    SER_SEND   // Frame bits presented one by one
  } ser_state_e;

  typedef enum logic {
    RX_HUNT,   // Waiting for a sampled 1
    RX_SHIFT   // Collecting id, payload and parity
  } rx_state_e;

endpackage

`default_nettype wire

//--- verilog/tag_packet_serializer.sv
`default_nettype none

module tag_packet_serializer (
    input  logic                                     clk_i
  , input  logic                                     reset_i
  , input  logic                                     pkt_v_i
  , input  logic [tag_pkg::tag_id_width_lp-1:0]      pkt_id_i
  , input  logic [tag_pkg::tag_payload_width_lp-1:0] pkt_data_i
  , output logic                                     pkt_ready_o
  , input  logic                                     raw_v_i
  , input  logic                                     raw_data_i
  , output logic                                     raw_ready_o
  , output logic                                     bit_v_o
  , output logic                                     bit_data_o
  , input  logic                                     bit_ready_i
);

  import tag_pkg::*;

  ser_state_e                    state_r;
  logic [tag_frame_bits_lp-1:0]  shift_r;     // Frame bits, MSB goes out first
  logic [tag_cnt_width_lp-1:0]   cnt_r;       // Frame bits already accepted
  logic                          parity;      // Even parity over id and payload
  logic                          pkt_accept;
  logic                          bit_accept;
  logic                          last_bit;

  assign parity     = ^{pkt_id_i, pkt_data_i};  // Makes id ^ payload ^ parity zero
  assign pkt_accept = pkt_v_i & pkt_ready_o;
  assign bit_accept = bit_v_o & bit_ready_i;
  assign last_bit   = (cnt_r == tag_cnt_width_lp'(tag_frame_bits_lp - 1));

  always_comb begin
    pkt_ready_o = (state_r == SER_IDLE);  // Packet port only open in idle
    raw_ready_o = 1'b0;
    bit_v_o     = 1'b0;
    bit_data_o  = shift_r[tag_frame_bits_lp-1];
    if (state_r == SER_SEND) begin
      bit_v_o = 1'b1;  // Held until bitbang takes it
    end else begin
      // Raw path straight through, packet wins if both present
      raw_ready_o = bit_ready_i & ~pkt_v_i;
      bit_v_o     = raw_v_i & ~pkt_v_i;
      bit_data_o  = raw_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= SER_IDLE;
      cnt_r   <= '0;
    end else begin
      case (state_r)
        SER_IDLE: begin
          if (pkt_accept) begin
            state_r <= SER_SEND;  // Frame loaded, first bit next cycle
            cnt_r   <= '0;
          end
        end
        SER_SEND: begin
          if (bit_accept) begin
            if (last_bit) begin
              state_r <= SER_IDLE;  // 12th bit gone
              cnt_r   <= '0;
            end else begin
              cnt_r <= cnt_r + tag_cnt_width_lp'(1);
            end
          end
        end
        default: begin
          state_r <= SER_IDLE;
          cnt_r   <= '0;
        end
      endcase
    end
  end

  // Frame shift register, start bit in the MSB
  always_ff @(posedge clk_i) begin
    if (pkt_accept) begin
      shift_r <= {1'b1, pkt_id_i, pkt_data_i, parity};
    end else if (bit_accept && (state_r == SER_SEND)) begin
      shift_r <= {shift_r[tag_frame_bits_lp-2:0], 1'b0};  // Next bit to the top
    end
  end

endmodule

`default_nettype wire

//--- verilog/tag_bitbang.sv
`default_nettype none

module tag_bitbang (
    input  logic clk_i
  , input  logic reset_i
  , input  logic data_i
  , input  logic v_i
  , output logic ready_and_o   // One bit every two clocks
  , output logic tag_clk_r_o   // Low for one cycle per bit
  , output logic tag_data_r_o  // Valid across the rising tag clock edge
);

  logic tag_clk_r;
  logic tag_data_r;
  logic handshake;

  assign handshake = ready_and_o & v_i;

  // Tag clock drops for a single cycle after each accepted bit
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tag_clk_r <= 1'b1;  // Idle high
    end else begin
      tag_clk_r <= ~handshake;
    end
  end

  always_ff @(posedge clk_i) begin
    if (handshake) begin
      tag_data_r <= data_i;  // Held until the next bit
    end
  end

  assign tag_clk_r_o  = tag_clk_r;
  assign tag_data_r_o = tag_data_r;
  assign ready_and_o  = tag_clk_r;  // Busy during the low cycle

endmodule

`default_nettype wire

//--- verilog/tag_frame_receiver.sv
`default_nettype none

module tag_frame_receiver (
    input  logic                     clk_i
  , input  logic                     reset_i
  , input  logic                     tag_clk_i
  , input  logic                     tag_data_i
  , output tag_pkg::tag_node_array_t node_o
  , output logic                     node_update_o
  , output logic                     frame_err_o
);

  import tag_pkg::*;

  rx_state_e                       state_r;
  logic                            tag_clk_prev_r;  // Tag clock one cycle ago
  logic [tag_frame_bits_lp-3:0]    shift_r;         // Id and payload so far
  logic [tag_cnt_width_lp-1:0]     cnt_r;           // Samples taken after start
  tag_node_array_t                 node_r;
  logic                            node_update_r;
  logic                            frame_err_r;
  logic                            rise;
  logic [tag_frame_bits_lp-2:0]    frame;           // Id, payload, parity
  logic                            frame_done;
  logic                            parity_ok;
  logic [tag_id_width_lp-1:0]      frame_id;
  logic [tag_payload_width_lp-1:0] frame_payload;

  assign rise = tag_clk_i & ~tag_clk_prev_r;  // Low last cycle, high now

  // Data is still the bit from the low cycle, so it can be sampled now
  assign frame         = {shift_r, tag_data_i};
  assign frame_done    = rise & (state_r == RX_SHIFT)
                       & (cnt_r == tag_cnt_width_lp'(tag_frame_bits_lp - 2));
  assign parity_ok     = ~^frame;  // Even parity over id, payload and parity
  assign frame_id      = frame[tag_frame_bits_lp-2 -: tag_id_width_lp];
  assign frame_payload = frame[tag_payload_width_lp:1];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tag_clk_prev_r <= 1'b1;  // Tag clock idles high
    end else begin
      tag_clk_prev_r <= tag_clk_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= RX_HUNT;
      cnt_r   <= '0;
    end else if (rise) begin
      case (state_r)
        RX_HUNT: begin
          if (tag_data_i) begin
            state_r <= RX_SHIFT;  // Start bit seen
            cnt_r   <= '0;
          end
        end
        RX_SHIFT: begin
          if (frame_done) begin
            state_r <= RX_HUNT;  // Eleventh sample closes the frame
            cnt_r   <= '0;
          end else begin
            cnt_r <= cnt_r + tag_cnt_width_lp'(1);
          end
        end
        default: begin
          state_r <= RX_HUNT;
          cnt_r   <= '0;
        end
      endcase
    end
  end

  // Shift only while inside a frame
  always_ff @(posedge clk_i) begin
    if (rise && (state_r == RX_SHIFT)) begin
      shift_r <= frame[tag_frame_bits_lp-3:0];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      node_r        <= '0;
      node_update_r <= 1'b0;
      frame_err_r   <= 1'b0;
    end else begin
      node_update_r <= frame_done & parity_ok;   // One cycle after last sample
      frame_err_r   <= frame_done & ~parity_ok;  // Bad frame dropped
      if (frame_done && parity_ok) begin
        node_r[frame_id] <= frame_payload;
      end
    end
  end

  assign node_o        = node_r;
  assign node_update_o = node_update_r;
  assign frame_err_o   = frame_err_r;

endmodule

`default_nettype wire

//--- verilog/tag_link_top.sv
`default_nettype none

module tag_link_top (
    input  logic                                     clk_i
  , input  logic                                     reset_i
  , input  logic                                     pkt_v_i
  , input  logic [tag_pkg::tag_id_width_lp-1:0]      pkt_id_i
  , input  logic [tag_pkg::tag_payload_width_lp-1:0] pkt_data_i
  , output logic                                     pkt_ready_o
  , input  logic                                     raw_v_i
  , input  logic                                     raw_data_i
  , output logic                                     raw_ready_o
  , output logic                                     tag_clk_o
  , output logic                                     tag_data_o
  , output tag_pkg::tag_node_array_t                 node_o
  , output logic                                     node_update_o
  , output logic                                     frame_err_o
);

  logic bit_v;      // Serializer bit stream
  logic bit_data;
  logic bit_ready;  // Bitbang idle
  logic tag_clk;    // Link wires
  logic tag_data;

  tag_packet_serializer ser (
      .clk_i       (clk_i)
    , .reset_i     (reset_i)
    , .pkt_v_i     (pkt_v_i)
    , .pkt_id_i    (pkt_id_i)
    , .pkt_data_i  (pkt_data_i)
    , .pkt_ready_o (pkt_ready_o)
    , .raw_v_i     (raw_v_i)
    , .raw_data_i  (raw_data_i)
    , .raw_ready_o (raw_ready_o)
    , .bit_v_o     (bit_v)
    , .bit_data_o  (bit_data)
    , .bit_ready_i (bit_ready)
  );

  tag_bitbang bitbang (
      .clk_i        (clk_i)
    , .reset_i      (reset_i)
    , .data_i       (bit_data)
    , .v_i          (bit_v)
    , .ready_and_o  (bit_ready)
    , .tag_clk_r_o  (tag_clk)
    , .tag_data_r_o (tag_data)
  );

  tag_frame_receiver rx (
      .clk_i         (clk_i)
    , .reset_i       (reset_i)
    , .tag_clk_i     (tag_clk)
    , .tag_data_i    (tag_data)
    , .node_o        (node_o)
    , .node_update_o (node_update_o)
    , .frame_err_o   (frame_err_o)
  );

  assign tag_clk_o  = tag_clk;   // Wires also leave the chip
  assign tag_data_o = tag_data;

endmodule

`default_nettype wire

//--- sim/tag_link_sva.sv
`default_nettype none

module tag_link_sva (
    input logic clk_i
  , input logic reset_i
  , input logic pkt_v_i
  , input logic pkt_ready_o
  , input logic tag_clk_o
  , input logic tag_data_o
  , input logic node_update_o
  , input logic frame_err_o
);

  timeunit 1ns;
  timeprecision 1ps;

  logic [4:0] busy_cnt_r;  // Packet cycles still to go

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_cnt_r <= '0;
    end else if (pkt_v_i && pkt_ready_o) begin
      busy_cnt_r <= 5'd23;  // Entry cycle plus 12 bits, minus this one
    end else if (busy_cnt_r != '0) begin
      busy_cnt_r <= busy_cnt_r - 5'd1;
    end
  end

  tag_clk_single_low: assert property (@(posedge clk_i) disable iff (reset_i)
    !tag_clk_o |=> tag_clk_o)
    else $error("tag_clk_o low for two cycles in a row");

  // Receiver samples data on the rising tag clock
  tag_data_at_rise: assert property (@(posedge clk_i) disable iff (reset_i)
    $rose(tag_clk_o) |-> $stable(tag_data_o))
    else $error("tag_data_o changed as tag_clk_o rose");

  pulse_exclusive: assert property (@(posedge clk_i) disable iff (reset_i)
    !(node_update_o && frame_err_o))
    else $error("node_update_o and frame_err_o high together");

  pkt_port_closed: assert property (@(posedge clk_i) disable iff (reset_i)
    (busy_cnt_r != '0) |-> !pkt_ready_o)
    else $error("pkt_ready_o high during a packet");

  pkt_port_reopens: assert property (@(posedge clk_i) disable iff (reset_i)
    (busy_cnt_r == 5'd1) |=> pkt_ready_o)
    else $error("pkt_ready_o still low after 24 packet cycles");

endmodule

bind tag_link_top tag_link_sva sva (
    .clk_i         (clk_i)
  , .reset_i       (reset_i)
  , .pkt_v_i       (pkt_v_i)
  , .pkt_ready_o   (pkt_ready_o)
  , .tag_clk_o     (tag_clk_o)
  , .tag_data_o    (tag_data_o)
  , .node_update_o (node_update_o)
  , .frame_err_o   (frame_err_o)
);

`default_nettype wire

//--- sim/tag_link_tb.sv
`default_nettype none

module tag_link_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import tag_pkg::*;

  logic                            clk_i = 1'b0;
  logic                            reset_i;
  logic                            pkt_v_i;
  logic [tag_id_width_lp-1:0]      pkt_id_i;
  logic [tag_payload_width_lp-1:0] pkt_data_i;
  logic                            pkt_ready_o;
  logic                            raw_v_i;
  logic                            raw_data_i;
  logic                            raw_ready_o;
  logic                            tag_clk_o;
  logic                            tag_data_o;
  tag_node_array_t                 node_o;
  logic                            node_update_o;
  logic                            frame_err_o;

  tag_node_array_t model_nodes;         // Expected node register contents
  logic [31:0]     rng_state;
  int              update_cnt    = 0;   // Update pulses seen since reset
  int              frame_err_cnt = 0;   // Error pulses seen since reset

  tag_link_top uut (.*);

  always #5 clk_i = ~clk_i;  // 10 ns clock

  // Pulse tally, read only at 1 ns after a rising edge
  always @(negedge clk_i) begin
    if (!reset_i && node_update_o) begin
      update_cnt <= update_cnt + 1;
    end
    if (!reset_i && frame_err_o) begin
      frame_err_cnt <= frame_err_cnt + 1;
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = lcg_next(rng_state);
    return rng_state;
  endfunction

  // Even parity bit from the frame rule, bit by bit
  function automatic logic even_parity(input logic [tag_id_width_lp-1:0] id,
                                       input logic [tag_payload_width_lp-1:0] data);
    logic p;
    p = 1'b0;
    for (int i = 0; i < tag_id_width_lp; i++) begin
      p = p ^ id[i];
    end
    for (int i = 0; i < tag_payload_width_lp; i++) begin
      p = p ^ data[i];
    end
    return p;
  endfunction

  task automatic stop_with_failure();
    $display("TEST FAIL");
    $fatal(1, "simulation stopped on the first failure");
  endtask

  task automatic check_fail(input string msg);
    $display("[ERROR] %0t %s", $time, msg);
    stop_with_failure();
  endtask

  task automatic timeout_fail(input string what);
    $display("Timeout: gave up waiting for %s", what);
    stop_with_failure();
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  // Starts and ends 1 ns after a rising edge
  task automatic send_packet(input logic [tag_id_width_lp-1:0] id,
                             input logic [tag_payload_width_lp-1:0] data);
    int                           waited;
    int                           lat;
    int                           lows;
    int                           upd_before;
    logic [tag_frame_bits_lp-1:0] frame;
    waited     = 0;
    lat        = 0;
    lows       = 0;
    upd_before = update_cnt;
    frame      = {1'b1, id, data, even_parity(id, data)};  // Expected bits on the wire
    pkt_v_i    = 1'b1;
    pkt_id_i   = id;
    pkt_data_i = data;
    @(negedge clk_i);
    while (!pkt_ready_o) begin
      waited++;
      if (waited > 40) timeout_fail("pkt_ready_o");
      @(negedge clk_i);
    end
    @(posedge clk_i);  // Packet taken on this edge
    #1;
    pkt_v_i          = 1'b0;
    model_nodes[id]  = data;
    @(negedge clk_i);
    while (!node_update_o) begin
      if (!tag_clk_o) begin
        if (lows < tag_frame_bits_lp) begin
          assert (tag_data_o == frame[tag_frame_bits_lp-1-lows])
            else check_fail($sformatf("tag_data_o %b in bit %0d, expected %b",
                                      tag_data_o, lows, frame[tag_frame_bits_lp-1-lows]));
        end
        lows++;  // One low cycle per frame bit
      end
      lat++;
      if (lat > 60) timeout_fail("node_update_o after a packet");
      @(negedge clk_i);
    end
    assert (lat == 25) else check_fail($sformatf("packet latency %0d, expected 25", lat));
    assert (lows == 12) else check_fail($sformatf("%0d tag clock lows, expected 12", lows));
    assert (node_o == model_nodes)
      else check_fail($sformatf("node_o %h, expected %h", node_o, model_nodes));
    @(negedge clk_i);
    assert (!node_update_o) else check_fail("node_update_o longer than one cycle");
    @(posedge clk_i);
    #1;
    assert (update_cnt == upd_before + 1) else check_fail("packet gave more than one update");
  endtask

  task automatic send_raw_bit(input logic b);
    int   waited;
    logic taken;
    waited     = 0;
    taken      = 1'b0;
    raw_v_i    = 1'b1;
    raw_data_i = b;
    while (!taken) begin
      @(negedge clk_i);
      taken = raw_ready_o;  // Accepted on the coming edge
      @(posedge clk_i);
      #1;
      if (!taken) begin
        waited++;
        if (waited > 40) timeout_fail("raw_ready_o");
      end
    end
    raw_v_i = 1'b0;
  endtask

  task automatic send_raw_frame(input logic [tag_id_width_lp-1:0] id,
                                input logic [tag_payload_width_lp-1:0] data,
                                input logic bad_parity, input int lead_zeros);
    logic [tag_frame_bits_lp-1:0] frame;
    logic [31:0]                  r;
    frame = {1'b1, id, data, even_parity(id, data) ^ bad_parity};
    for (int z = 0; z < lead_zeros; z++) begin
      send_raw_bit(1'b0);  // Receiver should stay hunting
    end
    for (int i = tag_frame_bits_lp - 1; i >= 0; i--) begin
      r = next_rand();
      idle_cycles(int'(r[29:28]));  // Gap before each bit
      send_raw_bit(frame[i]);
    end
  endtask

  task automatic wait_frame_result(input logic expect_err);
    int waited;
    waited = 0;
    @(negedge clk_i);
    while (!node_update_o && !frame_err_o) begin
      waited++;
      if (waited > 40) timeout_fail("a frame result pulse");
      @(negedge clk_i);
    end
    assert (frame_err_o == expect_err) else check_fail("wrong frame result pulse");
    assert (node_o == model_nodes)
      else check_fail($sformatf("node_o %h, expected %h", node_o, model_nodes));
    @(negedge clk_i);
    assert (!node_update_o && !frame_err_o) else check_fail("result pulse too long");
    @(posedge clk_i);
    #1;
  endtask

  initial begin
    logic [31:0]                     r;
    logic [tag_id_width_lp-1:0]      id;
    logic [tag_payload_width_lp-1:0] data;
    int                              expected_updates;
    reset_i          = 1'b1;
    pkt_v_i          = 1'b0;
    pkt_id_i         = '0;
    pkt_data_i       = '0;
    raw_v_i          = 1'b0;
    raw_data_i       = 1'b0;
    model_nodes      = '0;
    rng_state        = 32'h8a17;
    expected_updates = 0;
    repeat (10) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    @(negedge clk_i);
    assert (tag_clk_o && pkt_ready_o && raw_ready_o) else check_fail("link not idle after reset");
    assert (node_o == '0) else check_fail($sformatf("node_o %h after reset", node_o));
    assert (!node_update_o && !frame_err_o) else check_fail("pulse high after reset");
    @(posedge clk_i);
    #1;
    for (int n = 0; n < 20; n++) begin  // Random packets
      r    = next_rand();
      id   = r[31:30];
      data = r[23:16];
      send_packet(id, data);
      expected_updates++;
    end
    for (int n = 0; n < 4; n++) begin  // Good raw frames
      r    = next_rand();
      id   = r[31:30];
      data = r[23:16];
      send_raw_frame(id, data, 1'b0, 0);
      model_nodes[id] = data;
      wait_frame_result(1'b0);
      expected_updates++;
    end
    r = next_rand();
    send_raw_frame(r[31:30], r[23:16], 1'b1, 0);  // Inverted parity, model untouched
    wait_frame_result(1'b1);
    r    = next_rand();
    id   = r[31:30];
    data = r[23:16];
    send_raw_frame(id, data, 1'b0, 3);  // Three zeros ahead of the start bit
    model_nodes[id] = data;
    wait_frame_result(1'b0);
    expected_updates++;
    idle_cycles(4);
    assert (update_cnt == expected_updates)
      else check_fail($sformatf("%0d updates, expected %0d", update_cnt, expected_updates));
    assert (frame_err_cnt == 1)
      else check_fail($sformatf("%0d frame errors, expected 1", frame_err_cnt));
    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
verilog/tag_pkg.sv
verilog/tag_packet_serializer.sv
verilog/tag_bitbang.sv
verilog/tag_frame_receiver.sv
verilog/tag_link_top.sv
sim/tag_link_sva.sv
sim/tag_link_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the tag link simulation with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tag_link_tb \
  -f flist.f \
  -o tag_link_sim

./obj_dir/tag_link_sim
